// ==== all.f ====
rtl/sram_test_pkg.sv
rtl/sram_pattern_gen.sv
rtl/sram_controller.sv
rtl/sram_read_checker.sv
rtl/sram_tester.sv
rtl/sram_test_top.sv
verification/sram_model.sv
verification/sram_test_tb.sv

// ==== Bender.yml ====
package:
  name: sram_test

sources:
  - rtl/sram_test_pkg.sv
  - rtl/sram_pattern_gen.sv
  - rtl/sram_controller.sv
  - rtl/sram_read_checker.sv
  - rtl/sram_tester.sv
  - rtl/sram_test_top.sv
  - target: simulation
    files:
      - verification/sram_model.sv
      - verification/sram_test_tb.sv

// ==== verification/sram_test_tb.sv ====
`timescale 1ns/100ps

module sram_test_tb;

  import sram_test_pkg::*;

  localparam int ADDR_BITS   = 4;
  localparam int DATA_BITS   = 16;
  localparam int BIT_SEL     = $clog2(DATA_BITS);
  localparam int words       = 2**ADDR_BITS;
  localparam int run_timeout = 2000;

  logic                 clk;
  logic                 reset;
  logic                 test_done;
  logic                 test_pass;
  pattern_t             pattern_state;
  tester_state_t        tester_state;
  logic [DATA_BITS-1:0] mismatch_data;
  logic [DATA_BITS-1:0] mismatch_expected;
  logic [ADDR_BITS-1:0] sram_addr;
  wire  [DATA_BITS-1:0] sram_data;
  logic                 sram_we_n;
  logic                 sram_oe_n;
  logic                 sram_ce_n;
  logic                 fault_enable;
  logic [ADDR_BITS-1:0] fault_addr;
  logic [BIT_SEL-1:0]   fault_bit;
  logic                 fault_value;

  int       mismatch_count;
  int       failure_count;
  int       write_count;
  logic     pass_dropped;
  logic     done_seen;
  pattern_t pattern_log[$];

  sram_test_top #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_dut (
    .clk              (clk),
    .reset            (reset),
    .test_done        (test_done),
    .test_pass        (test_pass),
    .pattern_state    (pattern_state),
    .tester_state     (tester_state),
    .mismatch_data    (mismatch_data),
    .mismatch_expected(mismatch_expected),
    .sram_addr        (sram_addr),
    .sram_data        (sram_data),
    .sram_we_n        (sram_we_n),
    .sram_oe_n        (sram_oe_n),
    .sram_ce_n        (sram_ce_n)
  );

  sram_model #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_sram (
    .addr        (sram_addr),
    .data        (sram_data),
    .we_n        (sram_we_n),
    .oe_n        (sram_oe_n),
    .ce_n        (sram_ce_n),
    .fault_enable(fault_enable),
    .fault_addr  (fault_addr),
    .fault_bit   (fault_bit),
    .fault_value (fault_value)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // word each pattern should put at an address
  function automatic logic [DATA_BITS-1:0] rule_word(input pattern_t p,
                                                     input logic [ADDR_BITS-1:0] a);
    logic [DATA_BITS-1:0] word;
    case (p)
      zeros:     word = '0;
      ones:      word = '1;
      checker_5: word = 16'h5555;
      checker_a: word = 16'haaaa;
      addr_data: word = DATA_BITS'(a);
      addr_inv:  word = ~DATA_BITS'(a);
      default:   word = '0;
    endcase
    return word;
  endfunction

  // pattern list in its fixed order
  function automatic pattern_t nth_pattern(input int index);
    pattern_t p;
    case (index)
      0:       p = zeros;
      1:       p = ones;
      2:       p = checker_5;
      3:       p = checker_a;
      4:       p = addr_data;
      default: p = addr_inv;
    endcase
    return p;
  endfunction

  task automatic check_word(input string what, input logic [DATA_BITS-1:0] actual,
                            input logic [DATA_BITS-1:0] expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_flag(input string what, input logic actual, input logic expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_count(input string what, input int actual, input int expected);
    if (actual != expected) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic check_pattern(input string what, input pattern_t actual,
                               input pattern_t expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s is %s, expected %s", $time, what, actual.name(),
               expected.name());
    end
  endtask

  task automatic check_state(input string what, input tester_state_t actual,
                             input tester_state_t expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s is %s, expected %s", $time, what, actual.name(),
               expected.name());
    end
  endtask

  // pin writes, sticky flags and pattern history, sampled mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (!sram_ce_n && !sram_we_n) begin
        write_count++;
        check_word("written data", sram_data, rule_word(pattern_state, sram_addr));
      end
      if (!test_pass) begin
        pass_dropped = 1'b1;
      end
      if (test_done) begin
        done_seen = 1'b1;
      end
      if (pattern_log.size() == 0 || pattern_log[$] != pattern_state) begin
        pattern_log.push_back(pattern_state);
      end
    end
  end

  task automatic wait_done(input string phase, output logic seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < run_timeout) begin
      @(negedge clk);
      cycles++;
      seen = test_done;
    end
    if (!seen) begin
      failure_count++;
      $display("timeout: test_done did not pulse within %0d cycles in %s", run_timeout, phase);
    end
  endtask

  task automatic wait_pass_low(output logic fell);
    int cycles;
    fell   = 1'b0;
    cycles = 0;
    while (!fell && cycles < run_timeout) begin
      @(negedge clk);
      cycles++;
      fell = !test_pass;
    end
    if (!fell) begin
      failure_count++;
      $display("timeout: test_pass did not fall within %0d cycles of the fault", run_timeout);
    end
  endtask

  task automatic wait_halt();
    int cycles;
    cycles = 0;
    while (tester_state != halt && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (tester_state != halt) begin
      failure_count++;
      $display("timeout: tester did not halt within 10 cycles after test_pass fell");
    end
  endtask

  // four cycles of reset, idle pins checked before release
  task automatic apply_reset(input logic fault_after);
    @(negedge clk);
    reset = 1'b1;
    repeat (4) @(negedge clk);
    check_flag("test_pass in reset", test_pass, 1'b1);
    check_flag("test_done in reset", test_done, 1'b0);
    check_flag("sram_we_n in reset", sram_we_n, 1'b1);
    check_flag("sram_oe_n in reset", sram_oe_n, 1'b1);
    check_flag("sram_ce_n in reset", sram_ce_n, 1'b1);
    check_word("sram_data in reset", sram_data, {DATA_BITS{1'bz}});
    check_state("tester_state in reset", tester_state, start);
    fault_enable = fault_after;
    reset        = 1'b0;
  endtask

  // one full pass over all patterns with no fault
  task automatic run_clean(input string phase);
    logic seen;
    pattern_log.delete();
    pass_dropped = 1'b0;
    write_count  = 0;
    wait_done(phase, seen);
    if (!seen) begin
      return;
    end
    check_flag("test_pass dropped during clean run", pass_dropped, 1'b0);
    check_count("words written in one run", write_count, 6 * words);
    check_count("patterns visited", pattern_log.size(), 6);
    for (int i = 0; i < 6 && i < pattern_log.size(); i++) begin
      check_pattern("pattern order", pattern_log[i], nth_pattern(i));
    end
    @(negedge clk);
    check_pattern("pattern after test_done", pattern_state, zeros);
  endtask

  task automatic test_clean_run();
    apply_reset(1'b0);
    run_clean("first clean run");
    run_clean("repeated run");
  endtask

  task automatic test_injected_fault();
    pattern_t             first_fail;
    logic [DATA_BITS-1:0] word;
    logic                 found;
    logic                 fell;
    found      = 1'b0;
    first_fail = zeros;
    @(negedge clk);
    fault_addr  = ADDR_BITS'($urandom % words);
    fault_bit   = BIT_SEL'($urandom % DATA_BITS);
    fault_value = 1'($urandom % 2);
    // first pattern that disagrees with the stuck bit
    for (int i = 0; i < 6; i++) begin
      word = rule_word(nth_pattern(i), fault_addr);
      if (!found && word[fault_bit] != fault_value) begin
        found      = 1'b1;
        first_fail = nth_pattern(i);
      end
    end
    word            = rule_word(first_fail, fault_addr);
    word[fault_bit] = fault_value;
    apply_reset(1'b1);
    done_seen = 1'b0;
    wait_pass_low(fell);
    if (!fell) begin
      return;
    end
    wait_halt();
    // engine should stay parked
    repeat (20) @(negedge clk);
    check_state("tester_state after fault", tester_state, halt);
    check_flag("test_done seen after fault", done_seen, 1'b0);
    check_flag("test_pass after fault", test_pass, 1'b0);
    check_word("mismatch_expected", mismatch_expected, rule_word(first_fail, fault_addr));
    check_word("mismatch_data", mismatch_data, word);
  endtask

  task automatic test_reset_recovery();
    // fault stays in during reset, removed at release
    apply_reset(1'b0);
    run_clean("run after reset recovery");
  endtask

  initial begin
    int unsigned seed;
    reset          = 1'b1;
    fault_enable   = 1'b0;
    fault_addr     = '0;
    fault_bit      = '0;
    fault_value    = 1'b0;
    mismatch_count = 0;
    failure_count  = 0;
    write_count    = 0;
    pass_dropped   = 1'b0;
    done_seen      = 1'b0;
    seed           = $urandom(47);
    test_clean_run();
    test_injected_fault();
    test_reset_recovery();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== verification/sram_model.sv ====
`timescale 1ns/100ps

module sram_model #(
  parameter int ADDR_BITS = 4,
  parameter int DATA_BITS = 16
) (
  input  logic [ADDR_BITS-1:0]         addr,
  inout  wire  [DATA_BITS-1:0]         data,
  input  logic                         we_n,
  input  logic                         oe_n,
  input  logic                         ce_n,
  input  logic                         fault_enable,
  input  logic [ADDR_BITS-1:0]         fault_addr,
  input  logic [$clog2(DATA_BITS)-1:0] fault_bit,
  input  logic                         fault_value
);

  localparam int depth = 2**ADDR_BITS;

  logic [DATA_BITS-1:0] mem [depth];
  logic [DATA_BITS-1:0] stored_word;
  logic [DATA_BITS-1:0] fault_mask;
  logic [DATA_BITS-1:0] read_word;
  logic                 fault_hit;

  // write lands partway through the strobe, once the bus has settled
  always @(negedge we_n) begin
    #2;
    if (!ce_n && !we_n) begin
      mem[addr] = data;
    end
  end

  assign stored_word = mem[addr];
  assign fault_hit   = fault_enable && (addr == fault_addr);
  assign fault_mask  = {{(DATA_BITS-1){1'b0}}, 1'b1} << fault_bit;

  // stuck-at bit forced on the way out
  assign read_word = fault_hit ?
                     ((stored_word & ~fault_mask) | (fault_value ? fault_mask : '0)) :
                     stored_word;

  assign data = (!ce_n && !oe_n && we_n) ? read_word : 'z;

endmodule

// ==== rtl/sram_test_top.sv ====
`timescale 1ns/100ps

module sram_test_top #(
  parameter int ADDR_BITS = sram_test_pkg::default_addr_bits,
  parameter int DATA_BITS = sram_test_pkg::default_data_bits
) (
  input  logic                         clk,
  input  logic                         reset,
  output logic                         test_done,
  output logic                         test_pass,
  output sram_test_pkg::pattern_t      pattern_state,
  output sram_test_pkg::tester_state_t tester_state,
  output logic [DATA_BITS-1:0]         mismatch_data,
  output logic [DATA_BITS-1:0]         mismatch_expected,
  output logic [ADDR_BITS-1:0]         sram_addr,
  inout  wire  [DATA_BITS-1:0]         sram_data,
  output logic                         sram_we_n,
  output logic                         sram_oe_n,
  output logic                         sram_ce_n
);

  logic                 req;
  logic                 write_enable;
  logic [ADDR_BITS-1:0] addr;
  logic [DATA_BITS-1:0] write_data;
  logic                 ready;
  logic                 write_done;
  logic [DATA_BITS-1:0] read_data;
  logic                 read_data_valid;
  logic                 pattern_next;
  logic                 pattern_restart;
  logic [DATA_BITS-1:0] pattern_data;
  logic                 last_pattern;
  logic                 check_valid;
  logic [DATA_BITS-1:0] expected;
  logic [DATA_BITS-1:0] addr_low;

  // address fitted to the data width for the address patterns
  assign addr_low = DATA_BITS'(addr);

  sram_tester #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_tester (
    .clk            (clk),
    .reset          (reset),
    .ready          (ready),
    .write_done     (write_done),
    .read_data_valid(read_data_valid),
    .last_pattern   (last_pattern),
    .pass           (test_pass),
    .pattern_data   (pattern_data),
    .req            (req),
    .write_enable   (write_enable),
    .addr           (addr),
    .write_data     (write_data),
    .pattern_next   (pattern_next),
    .pattern_restart(pattern_restart),
    .check_valid    (check_valid),
    .expected       (expected),
    .test_done      (test_done),
    .tester_state   (tester_state)
  );

  sram_pattern_gen #(
    .DATA_BITS(DATA_BITS)
  ) u_pattern_gen (
    .clk            (clk),
    .reset          (reset),
    .pattern_next   (pattern_next),
    .pattern_restart(pattern_restart),
    .addr_low       (addr_low),
    .pattern_state  (pattern_state),
    .data           (pattern_data),
    .last_pattern   (last_pattern)
  );

  sram_controller #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_controller (
    .clk            (clk),
    .reset          (reset),
    .req            (req),
    .write_enable   (write_enable),
    .addr           (addr),
    .write_data     (write_data),
    .ready          (ready),
    .write_done     (write_done),
    .read_data      (read_data),
    .read_data_valid(read_data_valid),
    .io_addr        (sram_addr),
    .io_data        (sram_data),
    .io_we_n        (sram_we_n),
    .io_oe_n        (sram_oe_n),
    .io_ce_n        (sram_ce_n)
  );

  sram_read_checker #(
    .DATA_BITS(DATA_BITS)
  ) u_read_checker (
    .clk              (clk),
    .reset            (reset),
    .check_valid      (check_valid),
    .expected         (expected),
    .read_data        (read_data),
    .pass             (test_pass),
    .mismatch_data    (mismatch_data),
    .mismatch_expected(mismatch_expected)
  );

endmodule

// ==== rtl/sram_tester.sv ====
`timescale 1ns/100ps

module sram_tester #(
  parameter int ADDR_BITS = sram_test_pkg::default_addr_bits,
  parameter int DATA_BITS = sram_test_pkg::default_data_bits
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         ready,
  input  logic                         write_done,
  input  logic                         read_data_valid,
  input  logic                         last_pattern,
  input  logic                         pass,
  input  logic [DATA_BITS-1:0]         pattern_data,
  output logic                         req,
  output logic                         write_enable,
  output logic [ADDR_BITS-1:0]         addr,
  output logic [DATA_BITS-1:0]         write_data,
  output logic                         pattern_next,
  output logic                         pattern_restart,
  output logic                         check_valid,
  output logic [DATA_BITS-1:0]         expected,
  output logic                         test_done,
  output sram_test_pkg::tester_state_t tester_state
);

  import sram_test_pkg::*;

  tester_state_t state;
  tester_state_t next_state;
  logic          write_sweep;
  logic          last_addr;
  logic          word_done;
  logic          sweep_end;

  assign last_addr = &addr;

  // controller finished the word in flight
  assign word_done = (state == write_wait && write_done) ||
                     (state == read_wait && read_data_valid);

  // last word of a read sweep has come back
  assign sweep_end = (state == read_wait) && read_data_valid && last_addr;

  always_comb begin
    next_state = state;
    case (state)
      start: begin
        next_state = writing;
      end
      writing: begin
        if (ready) begin
          next_state = write_wait;
        end
      end
      write_wait: begin
        if (write_done) begin
          next_state = last_addr ? reading : writing;
        end
      end
      reading: begin
        if (ready) begin
          next_state = read_wait;
        end
      end
      read_wait: begin
        if (read_data_valid) begin
          if (!last_addr) begin
            next_state = reading;
          end else if (last_pattern) begin
            next_state = done;
          end else begin
            next_state = writing;
          end
        end
      end
      done: begin
        next_state = start;
      end
      halt: begin
        next_state = halt;
      end
      default: begin
        next_state = start;
      end
    endcase
  end

  // a failed compare stops the engine until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= start;
    end else if (!pass) begin
      state <= halt;
    end else begin
      state <= next_state;
    end
  end

  // direction of the sweep in progress
  always_ff @(posedge clk) begin
    if (reset) begin
      write_sweep <= 1'b1;
    end else if (next_state == writing) begin
      write_sweep <= 1'b1;
    end else if (next_state == reading) begin
      write_sweep <= 1'b0;
    end
  end

  // address counter, wraps back to zero after the top word
  always_ff @(posedge clk) begin
    if (reset || state == start) begin
      addr <= '0;
    end else if (word_done) begin
      addr <= last_addr ? '0 : addr + 1'b1;
    end
  end

  // one request per word, never while a failure is pending
  assign req = (state == writing || state == reading) && ready && pass;
  assign write_enable = write_sweep;

  assign write_data = write_sweep ? pattern_data : '0;
  assign expected   = write_sweep ? '0 : pattern_data;

  // checker sees the expected word alongside the read word
  assign check_valid = (state == read_wait) && read_data_valid;

  assign pattern_next    = sweep_end && !last_pattern;
  assign pattern_restart = (state == done);
  assign test_done       = (state == done);
  assign tester_state    = state;

endmodule

// ==== rtl/sram_read_checker.sv ====
`timescale 1ns/100ps

module sram_read_checker #(
  parameter int DATA_BITS = sram_test_pkg::default_data_bits
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 check_valid,
  input  logic [DATA_BITS-1:0] expected,
  input  logic [DATA_BITS-1:0] read_data,
  output logic                 pass,
  output logic [DATA_BITS-1:0] mismatch_data,
  output logic [DATA_BITS-1:0] mismatch_expected
);

  logic differs;
  logic first_fail;

  assign differs = (read_data != expected);

  // only the first failing word is kept
  assign first_fail = check_valid && pass && differs;

  // sticky until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      pass <= 1'b1;
    end else if (first_fail) begin
      pass <= 1'b0;
    end
  end

  // failing pair frozen for debug
  always_ff @(posedge clk) begin
    if (first_fail) begin
      mismatch_data     <= read_data;
      mismatch_expected <= expected;
    end
  end

endmodule

// ==== rtl/sram_controller.sv ====
`timescale 1ns/100ps

module sram_controller #(
  parameter int ADDR_BITS = sram_test_pkg::default_addr_bits,
  parameter int DATA_BITS = sram_test_pkg::default_data_bits
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req,
  input  logic                 write_enable,
  input  logic [ADDR_BITS-1:0] addr,
  input  logic [DATA_BITS-1:0] write_data,
  output logic                 ready,
  output logic                 write_done,
  output logic [DATA_BITS-1:0] read_data,
  output logic                 read_data_valid,
  output logic [ADDR_BITS-1:0] io_addr,
  inout  wire  [DATA_BITS-1:0] io_data,
  output logic                 io_we_n,
  output logic                 io_oe_n,
  output logic                 io_ce_n
);

  import sram_test_pkg::*;

  ctrl_state_t          state;
  logic                 write_q;
  logic                 drive_en;
  logic [DATA_BITS-1:0] write_data_q;

  // busy only while the pins are in their access cycle
  assign ready = (state != access);

  // data bus released except during a write access
  assign io_data = drive_en ? write_data_q : 'z;

  always_ff @(posedge clk) begin
    if (reset) begin
      state           <= idle;
      write_q         <= 1'b0;
      drive_en        <= 1'b0;
      write_done      <= 1'b0;
      read_data_valid <= 1'b0;
      io_we_n         <= 1'b1;
      io_oe_n         <= 1'b1;
      io_ce_n         <= 1'b1;
    end else begin
      write_done      <= 1'b0;
      read_data_valid <= 1'b0;
      case (state)
        access: begin
          // end of the access, strobes go inactive
          io_ce_n  <= 1'b1;
          io_we_n  <= 1'b1;
          io_oe_n  <= 1'b1;
          drive_en <= 1'b0;
          if (write_q) begin
            write_done <= 1'b1;
          end else begin
            read_data_valid <= 1'b1;
          end
          state <= finish;
        end
        default: begin
          // idle or finish, a new request starts the pin cycle
          if (req) begin
            write_q  <= write_enable;
            drive_en <= write_enable;
            io_ce_n  <= 1'b0;
            io_we_n  <= ~write_enable;
            io_oe_n  <= write_enable;
            state    <= access;
          end else begin
            state <= idle;
          end
        end
      endcase
    end
  end

  // address and write word held on the pins through the access
  always_ff @(posedge clk) begin
    if (ready && req) begin
      io_addr      <= addr;
      write_data_q <= write_data;
    end
  end

  // read word sampled at the end of the access cycle
  always_ff @(posedge clk) begin
    if (state == access && !write_q) begin
      read_data <= io_data;
    end
  end

endmodule

// ==== rtl/sram_pattern_gen.sv ====
`timescale 1ns/100ps

module sram_pattern_gen #(
  parameter int DATA_BITS = sram_test_pkg::default_data_bits
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    pattern_next,
  input  logic                    pattern_restart,
  input  logic [DATA_BITS-1:0]    addr_low,
  output sram_test_pkg::pattern_t pattern_state,
  output logic [DATA_BITS-1:0]    data,
  output logic                    last_pattern
);

  import sram_test_pkg::*;

  // alternating bits, lsb selects 0x5 or 0xa style
  function automatic logic [DATA_BITS-1:0] alternating(input logic lsb);
    logic [DATA_BITS-1:0] word;
    for (int i = 0; i < DATA_BITS; i++) begin
      word[i] = lsb ^ i[0];
    end
    return word;
  endfunction

  localparam logic [DATA_BITS-1:0] checker_5_word = alternating(1'b1);
  localparam logic [DATA_BITS-1:0] checker_a_word = alternating(1'b0);

  pattern_t pattern_following;

  // step order of the pattern list
  always_comb begin
    case (pattern_state)
      zeros:     pattern_following = ones;
      ones:      pattern_following = checker_5;
      checker_5: pattern_following = checker_a;
      checker_a: pattern_following = addr_data;
      addr_data: pattern_following = addr_inv;
      default:   pattern_following = zeros;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || pattern_restart) begin
      pattern_state <= zeros;
    end else if (pattern_next) begin
      pattern_state <= pattern_following;
    end
  end

  // word for the current address
  always_comb begin
    case (pattern_state)
      zeros:     data = '0;
      ones:      data = '1;
      checker_5: data = checker_5_word;
      checker_a: data = checker_a_word;
      addr_data: data = addr_low;
      addr_inv:  data = ~addr_low;
      default:   data = '0;
    endcase
  end

  assign last_pattern = (pattern_state == addr_inv);

endmodule

// ==== rtl/sram_test_pkg.sv ====
package sram_test_pkg;

  // default widths, overridden from the top level
  parameter int default_addr_bits = 20;
  parameter int default_data_bits = 16;

  // sequencing states of the tester
  typedef enum logic [2:0] {
    start,
    writing,
    write_wait,
    reading,
    read_wait,
    done,
    halt
  } tester_state_t;

  // data patterns, stepped in this order
  typedef enum logic [2:0] {
    zeros,
    ones,
    checker_5,
    checker_a,
    addr_data,
    addr_inv
  } pattern_t;

  // sram controller phases
  typedef enum logic [1:0] {
    idle,
    access,
    finish
  } ctrl_state_t;

endpackage
